//--- pingpong_buffer.f
+incdir+rtl
rtl/pp_data_pkg.sv
rtl/pp_ctrl_pkg.sv
rtl/pp_bank_if.sv
rtl/pp_swap_ctrl.sv
rtl/pp_ram_bank.sv
rtl/pingpong_buffer.sv
sim/pp_checker.sv
sim/pp_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the ping-pong buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f pingpong_buffer.f --top-module pp_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vpp_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation binary returned status $status"
    exit 1
fi

# The testbench prints the pass line only when every check held
if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

//--- sim/pp_tb.sv
`timescale 1ns/1ns
`include "pp_defines.svh"

module pp_tb
    import pp_data_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int RUN_CYCLES      = 4000;
    localparam int PHASE_CYCLES    = 500;              // Fast and slow read phases alternate
    localparam int WATCHDOG_CYCLES = RUN_CYCLES * 3 / 2;

    logic    clk_i;
    logic    rst_ni;
    sample_t write_data;
    logic    write_valid;
    logic    write_ready;
    sample_t read_data;
    logic    read_valid;
    logic    read_ready;
    logic    buffer_ready;
    count_t  write_count;
    count_t  read_count;

    logic [31:0] rng_state = 32'd58;
    int error_count;
    int check_count;
    int swap_count;
    int drained_count;
    int replaced_count;
    int total_errors;

    // ===================================================================
    // Clock, DUT and checker
    // ===================================================================

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    pingpong_buffer i_dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .write_data_i   (write_data),
        .write_valid_i  (write_valid),
        .write_ready_o  (write_ready),
        .read_data_o    (read_data),
        .read_valid_o   (read_valid),
        .read_ready_i   (read_ready),
        .buffer_ready_o (buffer_ready),
        .write_count_o  (write_count),
        .read_count_o   (read_count)
    );

    pp_checker i_checker (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .write_data_i     (write_data),
        .write_valid_i    (write_valid),
        .write_ready_i    (write_ready),
        .read_data_i      (read_data),
        .read_valid_i     (read_valid),
        .read_ready_i     (read_ready),
        .buffer_ready_i   (buffer_ready),
        .write_count_i    (write_count),
        .read_count_i     (read_count),
        .error_count_o    (error_count),
        .check_count_o    (check_count),
        .swap_count_o     (swap_count),
        .drained_count_o  (drained_count),
        .replaced_count_o (replaced_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One cycle of random write and read traffic
    task automatic drive_inputs(input int cycle);
        logic fast_reads;
        fast_reads  = ((cycle / PHASE_CYCLES) % 2) == 0;
        rng_state   = xorshift32(rng_state);
        write_valid = (rng_state[1:0] != 2'b00);        // About 3 in 4
        rng_state   = xorshift32(rng_state);
        write_data  = sample_t'(rng_state);
        rng_state   = xorshift32(rng_state);
        if (fast_reads) begin
            read_ready = (rng_state[2:0] != 3'b000);    // About 7 in 8
        end else begin
            read_ready = (rng_state[1:0] == 2'b00);     // About 1 in 4
        end
    endtask

    // ===================================================================
    // Stimulus and result
    // ===================================================================

    initial begin
        rst_ni      = 1'b0;
        write_data  = '0;
        write_valid = 1'b0;
        read_ready  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            drive_inputs(cycle);
            @(negedge clk_i);   // Previous inputs were sampled at the rising edge
        end
        write_valid  = 1'b0;
        read_ready   = 1'b0;
        total_errors = error_count;
        if (drained_count == 0) begin
            $display("No buffer was ever read out completely");
            total_errors++;
        end
        if (replaced_count == 0) begin
            $display("No buffer was ever replaced before it was read out");
            total_errors++;
        end
        $display("Checks: %0d, errors: %0d, swaps: %0d, drained: %0d, replaced: %0d",
                 check_count, total_errors, swap_count, drained_count, replaced_count);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Simulation hung, the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim/pp_checker.sv
`timescale 1ns/1ns
`include "pp_defines.svh"

module pp_checker
    import pp_data_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    input  sample_t write_data_i,
    input  logic    write_valid_i,
    input  logic    write_ready_i,    // DUT write_ready_o
    input  sample_t read_data_i,      // DUT read_data_o
    input  logic    read_valid_i,     // DUT read_valid_o
    input  logic    read_ready_i,
    input  logic    buffer_ready_i,   // DUT buffer_ready_o
    input  count_t  write_count_i,
    input  count_t  read_count_i,
    output int      error_count_o,
    output int      check_count_o,
    output int      swap_count_o,
    output int      drained_count_o,  // Buffers read out completely
    output int      replaced_count_o  // Buffers swapped out while still valid
);

    // ===================================================================
    // Reference model state, values seen before the current edge
    // ===================================================================

    sample_t fill_q [$];              // Accepted samples since the last swap, in write order
    sample_t drain_mem [`PP_DEPTH];   // Snapshot of the buffer being drained
    int      read_pos;
    logic    read_valid_exp;
    logic    pulse_exp;
    logic    swap_pending;            // Model is in the exchange cycle
    logic    ready_exp;
    logic    write_ok;
    logic    read_ok;

    int error_count    = 0;
    int check_count    = 0;
    int swap_count     = 0;
    int drained_count  = 0;
    int replaced_count = 0;

    assign error_count_o    = error_count;
    assign check_count_o    = check_count;
    assign swap_count_o     = swap_count;
    assign drained_count_o  = drained_count;
    assign replaced_count_o = replaced_count;

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // ===================================================================
    // Compare, then advance the model by one clock
    // ===================================================================

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            fill_q.delete();
            read_pos       = 0;
            read_valid_exp = 1'b0;
            pulse_exp      = 1'b0;
            swap_pending   = 1'b0;
        end else begin
            ready_exp = (fill_q.size() < `PP_DEPTH);   // Full only in the exchange cycle
            compare_value("write_ready_o", 64'(write_ready_i), 64'(ready_exp));
            compare_value("write_count_o", 64'(write_count_i), 64'(fill_q.size()));
            compare_value("buffer_ready_o", 64'(buffer_ready_i), 64'(pulse_exp));
            compare_value("read_valid_o", 64'(read_valid_i), 64'(read_valid_exp));
            compare_value("read_count_o", 64'(read_count_i), 64'(read_pos));
            if (read_valid_exp) begin
                compare_value("read_data_o", 64'(read_data_i), 64'(drain_mem[read_pos]));
            end

            write_ok = write_valid_i && ready_exp;
            read_ok  = read_valid_exp && read_ready_i;

            if (swap_pending) begin
                // Unread samples of the old buffer are lost
                if (read_valid_exp) begin
                    replaced_count++;
                end
                for (int i = 0; i < `PP_DEPTH; i++) begin
                    drain_mem[i] = fill_q[i];
                end
                fill_q.delete();
                read_pos       = 0;
                read_valid_exp = 1'b1;
                pulse_exp      = 1'b1;
                swap_pending   = 1'b0;
                swap_count++;
            end else begin
                pulse_exp = 1'b0;
                if (write_ok) begin
                    fill_q.push_back(write_data_i);
                    swap_pending = (fill_q.size() == `PP_DEPTH);   // Forced swap next cycle
                end
                if (read_ok) begin
                    read_pos++;
                    if (read_pos == `PP_DEPTH) begin
                        read_valid_exp = 1'b0;   // Idle until the next pulse
                        drained_count++;
                    end
                end
            end
        end
    end

endmodule

//--- rtl/pingpong_buffer.sv
`timescale 1ns/1ns
`include "pp_defines.svh"

module pingpong_buffer
    import pp_data_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,

    // Write port
    input  sample_t write_data_i,
    input  logic    write_valid_i,
    output logic    write_ready_o,

    // Read port
    output sample_t read_data_o,
    output logic    read_valid_o,
    input  logic    read_ready_i,

    // Status
    output logic    buffer_ready_o,  // New read buffer available
    output count_t  write_count_o,
    output count_t  read_count_o
);

    // ===================================================================
    // Controller and memories
    // ===================================================================

    pp_bank_if i_bank_if ();

    pp_swap_ctrl i_swap_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .write_valid_i  (write_valid_i),
        .write_ready_o  (write_ready_o),
        .read_ready_i   (read_ready_i),
        .read_valid_o   (read_valid_o),
        .buffer_ready_o (buffer_ready_o),
        .write_count_o  (write_count_o),
        .read_count_o   (read_count_o),
        .bank           (i_bank_if.ctrl)
    );

    // Write data bypasses the controller
    pp_ram_bank i_ram_bank (
        .clk_i        (clk_i),
        .write_data_i (write_data_i),
        .read_data_o  (read_data_o),
        .bank         (i_bank_if.bank)
    );

endmodule

//--- rtl/pp_ram_bank.sv
`timescale 1ns/1ns
`include "pp_defines.svh"

module pp_ram_bank
    import pp_data_pkg::*;
(
    input  logic    clk_i,
    input  sample_t write_data_i,
    output sample_t read_data_o,    // Follows rd_sel and rd_addr combinationally
    pp_bank_if.bank bank
);

    // ===================================================================
    // Two sample memories
    // ===================================================================

    sample_t mem_q [2][`PP_DEPTH];  // No reset, contents undefined until written

    logic [1:0]   mem_we;           // Per-memory write enable
    sample_t      mem_rdata [2];    // Per-memory read word

    // Write steering, only the fill memory sees the enable
    assign mem_we[0] = bank.wr_en && (bank.wr_sel == 1'b0);
    assign mem_we[1] = bank.wr_en && (bank.wr_sel == 1'b1);

    for (genvar m = 0; m < 2; m++) begin : g_mem
        // Synchronous write
        always_ff @(posedge clk_i) begin
            if (mem_we[m]) begin
                mem_q[m][bank.wr_addr] <= write_data_i;
            end
        end

        // Asynchronous read at the drain position
        assign mem_rdata[m] = mem_q[m][bank.rd_addr];
    end

    // Read multiplexing
    assign read_data_o = bank.rd_sel ? mem_rdata[1] : mem_rdata[0];

endmodule

//--- rtl/pp_swap_ctrl.sv
`timescale 1ns/1ns
`include "pp_defines.svh"

module pp_swap_ctrl
    import pp_data_pkg::*;
    import pp_ctrl_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   write_valid_i,
    output logic   write_ready_o,
    input  logic   read_ready_i,
    output logic   read_valid_o,
    output logic   buffer_ready_o,   // One-cycle pulse per new read buffer
    output count_t write_count_o,    // Fill level of the write buffer
    output count_t read_count_o,     // Samples delivered from the read buffer
    pp_bank_if.ctrl bank
);

    // ===================================================================
    // Registers and handshake qualifiers
    // ===================================================================

    buffer_state_t state_q, state_d;

    addr_t  write_addr_q;
    addr_t  read_addr_q;
    count_t write_count_q;
    count_t read_count_q;

    logic   write_sel_q;    // 0 selects memory 0 for filling
    logic   read_sel_q;     // Always the opposite memory of write_sel_q
    logic   read_valid_q;
    logic   buffer_ready_q;

    logic   write_accepted;
    logic   read_accepted;
    logic   write_last;     // This write completes the buffer
    logic   read_last;      // This delivery drains the buffer

    assign write_accepted = write_valid_i && write_ready_o;
    assign read_accepted  = read_valid_q && read_ready_i;

    assign write_last = write_accepted && (write_count_q == count_t'(`PP_DEPTH - 1));
    assign read_last  = read_accepted && (read_count_q == count_t'(`PP_DEPTH - 1));

    // Combinational so a freed buffer takes writes right after the swap
    assign write_ready_o = (write_count_q < count_t'(`PP_DEPTH));

    // ===================================================================
    // Swap state machine
    // ===================================================================

    always_comb begin
        state_d = state_q;                  // Hold by default
        case (state_q)
            WRITING: begin
                if (write_last) begin
                    state_d = SWAP_PENDING; // First buffer just filled
                end
            end
            SWAP_PENDING: begin
                state_d = READING;          // Swap happens at the end of this cycle
            end
            READING: begin
                if (write_last) begin
                    state_d = SWAP_PENDING;
                end
            end
            default: state_d = WRITING;
        endcase
    end

    // ===================================================================
    // Addresses, counts, selects and read valid
    // ===================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q        <= WRITING;
            write_addr_q   <= '0;
            read_addr_q    <= '0;
            write_count_q  <= '0;
            read_count_q   <= '0;
            write_sel_q    <= 1'b0;    // Fill memory 0 first
            read_sel_q     <= 1'b1;
            read_valid_q   <= 1'b0;
            buffer_ready_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            buffer_ready_q <= 1'b0;    // Pulse lasts one cycle

            if (state_q == SWAP_PENDING) begin
                // Full buffer becomes the read buffer, unread samples are dropped
                read_sel_q     <= write_sel_q;
                write_sel_q    <= ~write_sel_q;
                write_addr_q   <= '0;
                write_count_q  <= '0;
                read_addr_q    <= '0;
                read_count_q   <= '0;
                read_valid_q   <= 1'b1;
                buffer_ready_q <= 1'b1;
            end else begin
                if (write_accepted) begin
                    write_addr_q  <= write_addr_q + 1'b1;
                    write_count_q <= write_count_q + 1'b1;
                end

                if (read_accepted) begin
                    read_addr_q  <= read_addr_q + 1'b1;   // Wraps to 0 after the last one
                    read_count_q <= read_count_q + 1'b1;
                end

                // Drained, stay idle until the next swap
                if (read_last) begin
                    read_valid_q <= 1'b0;
                end
            end
        end
    end

    // Outputs
    assign read_valid_o   = read_valid_q;
    assign buffer_ready_o = buffer_ready_q;
    assign write_count_o  = write_count_q;
    assign read_count_o   = read_count_q;

    // Bank control
    assign bank.wr_en   = write_accepted;
    assign bank.wr_sel  = write_sel_q;
    assign bank.wr_addr = write_addr_q;
    assign bank.rd_sel  = read_sel_q;
    assign bank.rd_addr = read_addr_q;

endmodule

//--- rtl/pp_bank_if.sv
`timescale 1ns/1ns

// Controller to RAM bank link, one write port and one read port
interface pp_bank_if
    import pp_data_pkg::*;
();

    logic  wr_en;       // One cycle per accepted sample
    logic  wr_sel;      // Memory being filled
    addr_t wr_addr;     // Fill position
    logic  rd_sel;      // Memory being drained
    addr_t rd_addr;     // Drain position

    // Controller side drives everything
    modport ctrl (
        output wr_en,
        output wr_sel,
        output wr_addr,
        output rd_sel,
        output rd_addr
    );

    // Bank side only consumes
    modport bank (
        input wr_en,
        input wr_sel,
        input wr_addr,
        input rd_sel,
        input rd_addr
    );

endinterface

//--- rtl/pp_ctrl_pkg.sv
package pp_ctrl_pkg;

    // Swap state machine
    typedef enum logic [1:0] {
        WRITING,        // Filling only, nothing to drain yet
        SWAP_PENDING,   // Single cycle where the buffers trade roles
        READING         // Filling one buffer, draining the other
    } buffer_state_t;

endpackage

//--- rtl/pp_data_pkg.sv
`include "pp_defines.svh"

package pp_data_pkg;

    // One stream sample, signed as produced by the ADC path
    typedef logic signed [`PP_DATA_WIDTH-1:0] sample_t;

    typedef logic [`PP_ADDR_WIDTH-1:0] addr_t;     // Position inside one buffer

    // One extra bit so a full buffer (PP_DEPTH) fits
    typedef logic [`PP_ADDR_WIDTH:0] count_t;

endpackage

//--- rtl/pp_defines.svh
`ifndef PP_DEFINES_SVH
`define PP_DEFINES_SVH

// Bits per sample
`define PP_DATA_WIDTH 32

// Samples per buffer, power of two
`define PP_DEPTH      64

// Address bits, log2 of PP_DEPTH
`define PP_ADDR_WIDTH 6

`endif
